//--- csrPkg.sv
// Machine-mode CSR subsystem definitions
// Widths, CSR numbers, bit positions, cause codes and the structs
// passed between the control and datapath blocks
package csrPkg;

    localparam int XLEN      = 32;
    localparam int CSR_NUM_W = 12;
    localparam int CAUSE_W   = 5;
    localparam int CTR_W     = 64;

    typedef logic [XLEN-1:0]      wordT;
    typedef logic [XLEN-1:0]      addrT;
    typedef logic [CSR_NUM_W-1:0] csrNumT;
    typedef logic [CAUSE_W-1:0]   causeT;
    typedef logic [1:0]           retireCountT;   // 0 to 3 per cycle
    typedef logic [CTR_W-1:0]     ctrT;

    // Machine-mode CSR addresses
    localparam csrNumT CSR_MSTATUS   = 12'h300;
    localparam csrNumT CSR_MIE       = 12'h304;
    localparam csrNumT CSR_MTVEC     = 12'h305;
    localparam csrNumT CSR_MSCRATCH  = 12'h340;
    localparam csrNumT CSR_MEPC      = 12'h341;
    localparam csrNumT CSR_MCAUSE    = 12'h342;
    localparam csrNumT CSR_MTVAL     = 12'h343;
    localparam csrNumT CSR_MIP       = 12'h344;
    localparam csrNumT CSR_MCYCLE    = 12'hB00;
    localparam csrNumT CSR_MINSTRET  = 12'hB02;
    localparam csrNumT CSR_MCYCLEH   = 12'hB80;
    localparam csrNumT CSR_MINSTRETH = 12'hB82;

    localparam int MIE_BIT  = 3;    // mstatus
    localparam int MPIE_BIT = 7;
    localparam int MTI_BIT  = 7;    // mie / mip
    localparam int MEI_BIT  = 11;

    localparam causeT CAUSE_MTI = 5'd7;
    localparam causeT CAUSE_MEI = 5'd11;

    // One-hot counter write enables
    localparam int CTR_CYCLE_LO   = 0;
    localparam int CTR_CYCLE_HI   = 1;
    localparam int CTR_INSTRET_LO = 2;
    localparam int CTR_INSTRET_HI = 3;

    typedef enum logic [2:0] {
        REQ_CSRRW = 3'd0,
        REQ_CSRRS = 3'd1,
        REQ_CSRRC = 3'd2,
        REQ_TRAP  = 3'd3,
        REQ_MRET  = 3'd4
    } reqKindT;

    typedef enum logic [2:0] {
        CMD_NONE = 3'd0,
        CMD_OP   = 3'd1,
        CMD_TRAP = 3'd2,
        CMD_MRET = 3'd3,
        CMD_IRQ  = 3'd4
    } cmdKindT;

    typedef enum logic {
        S_IDLE = 1'b0,
        S_RESP = 1'b1
    } ctrlStateT;

    typedef struct packed {
        reqKindT kind;
        csrNumT  csrNum;
        wordT    wdata;
        addrT    pc;
        wordT    tval;
        causeT   cause;
    } csrReqT;

    typedef struct packed {
        wordT rdata;
        logic redirect;
        addrT target;
        logic irqTaken;
    } csrRespT;

    typedef struct packed {
        cmdKindT kind;
        reqKindT op;
        csrNumT  csrNum;
        wordT    wdata;
        addrT    epc;
        wordT    tval;
        causeT   cause;
    } csrCmdT;

    typedef struct packed {
        logic [3:0] we;
        wordT       wdata;
    } ctrWriteT;

    typedef struct packed {
        ctrT mcycle;
        ctrT minstret;
    } ctrValueT;

endpackage

//--- retireCounters.sv
// mcycle and minstret counters
// 64-bit free-running cycle count and retired-instruction count,
// each half writable from the CSR file
`timescale 1ns/1ps

module retireCounters (
    input  logic                 clk,
    input  logic                 arstN,
    input  csrPkg::retireCountT  retireCount,
    input  csrPkg::ctrWriteT     ctrWrite,
    output csrPkg::ctrValueT     counters
);
    import csrPkg::*;

    ctrT cycleReg;
    ctrT instretReg;
    ctrT cycleNext;
    ctrT instretNext;

    always_comb begin
        // A write to either half holds off the increment for this edge
        if (ctrWrite.we[CTR_CYCLE_LO] || ctrWrite.we[CTR_CYCLE_HI]) begin
            cycleNext = cycleReg;
            if (ctrWrite.we[CTR_CYCLE_LO]) cycleNext[XLEN-1:0] = ctrWrite.wdata;
            if (ctrWrite.we[CTR_CYCLE_HI]) cycleNext[CTR_W-1:XLEN] = ctrWrite.wdata;
        end else begin
            cycleNext = cycleReg + 64'd1;   // Carry into high half is native
        end

        if (ctrWrite.we[CTR_INSTRET_LO] || ctrWrite.we[CTR_INSTRET_HI]) begin
            instretNext = instretReg;
            if (ctrWrite.we[CTR_INSTRET_LO]) instretNext[XLEN-1:0] = ctrWrite.wdata;
            if (ctrWrite.we[CTR_INSTRET_HI]) instretNext[CTR_W-1:XLEN] = ctrWrite.wdata;
        end else begin
            instretNext = instretReg + CTR_W'(retireCount);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycleReg   <= '0;
            instretReg <= '0;
        end else begin
            cycleReg   <= cycleNext;
            instretReg <= instretNext;
        end
    end

    assign counters.mcycle   = cycleReg;
    assign counters.minstret = instretReg;

endmodule

//--- interruptArbiter.sv
// Machine interrupt arbiter
// Masks registered pending bits with mie and the global enable,
// external interrupt ahead of timer
`timescale 1ns/1ps

module interruptArbiter (
    input  csrPkg::wordT   mieBits,
    input  csrPkg::wordT   mipBits,
    input  logic           globalIe,
    output logic           irqValid,
    output csrPkg::causeT  irqCause
);
    import csrPkg::*;

    wordT enabled;
    logic timerPend;
    logic extPend;

    assign enabled   = mieBits & mipBits;
    assign timerPend = globalIe && enabled[MTI_BIT];
    assign extPend   = globalIe && enabled[MEI_BIT];

    assign irqValid = timerPend || extPend;

    // Fixed priority
    always_comb begin
        if (extPend) begin
            irqCause = CAUSE_MEI;
        end else begin
            irqCause = CAUSE_MTI;
        end
    end

endmodule

//--- csrFile.sv
// Machine-mode CSR register file
// Combinational read of the addressed CSR, read-modify-write on the edge,
// trap / interrupt entry and MRET updates of mstatus, mepc, mcause, mtval
`timescale 1ns/1ps

module csrFile (
    input  logic              clk,
    input  logic              arstN,
    input  csrPkg::csrCmdT    cmd,
    input  logic              timerIrq,
    input  logic              extIrq,
    input  csrPkg::ctrValueT  counters,
    output csrPkg::ctrWriteT  ctrWrite,
    output csrPkg::wordT      rdata,
    output csrPkg::addrT      mtvecBase,
    output csrPkg::addrT      mepc,
    output csrPkg::wordT      mieBits,
    output csrPkg::wordT      mipBits,
    output logic              globalIe
);
    import csrPkg::*;

    logic statusMie;
    logic statusMpie;
    wordT mieReg;
    addrT mtvecReg;     // Direct mode only, low bits held at zero
    wordT mscratchReg;
    addrT mepcReg;
    wordT mcauseReg;
    wordT mtvalReg;
    logic mipTimer;
    logic mipExt;

    wordT mstatusVal;
    wordT mipVal;
    wordT newVal;
    logic opWrite;

    // Sparse views of mstatus and mip
    always_comb begin
        mstatusVal = '0;
        mstatusVal[MIE_BIT]  = statusMie;
        mstatusVal[MPIE_BIT] = statusMpie;
        mipVal = '0;
        mipVal[MTI_BIT] = mipTimer;
        mipVal[MEI_BIT] = mipExt;
    end

    always_comb begin
        case (cmd.csrNum)
            CSR_MSTATUS:   rdata = mstatusVal;
            CSR_MIE:       rdata = mieReg;
            CSR_MTVEC:     rdata = mtvecReg;
            CSR_MSCRATCH:  rdata = mscratchReg;
            CSR_MEPC:      rdata = mepcReg;
            CSR_MCAUSE:    rdata = mcauseReg;
            CSR_MTVAL:     rdata = mtvalReg;
            CSR_MIP:       rdata = mipVal;
            CSR_MCYCLE:    rdata = counters.mcycle[XLEN-1:0];
            CSR_MCYCLEH:   rdata = counters.mcycle[CTR_W-1:XLEN];
            CSR_MINSTRET:  rdata = counters.minstret[XLEN-1:0];
            CSR_MINSTRETH: rdata = counters.minstret[CTR_W-1:XLEN];
            default:       rdata = '0;   // Unmapped reads zero
        endcase
    end

    // Write, set or clear against the old value
    always_comb begin
        case (cmd.op)
            REQ_CSRRS: newVal = rdata | cmd.wdata;
            REQ_CSRRC: newVal = rdata & ~cmd.wdata;
            default:   newVal = cmd.wdata;
        endcase
    end

    assign opWrite = (cmd.kind == CMD_OP);

    // Counter halves live in retireCounters
    always_comb begin
        ctrWrite.we    = '0;
        ctrWrite.wdata = newVal;
        if (opWrite) begin
            ctrWrite.we[CTR_CYCLE_LO]   = (cmd.csrNum == CSR_MCYCLE);
            ctrWrite.we[CTR_CYCLE_HI]   = (cmd.csrNum == CSR_MCYCLEH);
            ctrWrite.we[CTR_INSTRET_LO] = (cmd.csrNum == CSR_MINSTRET);
            ctrWrite.we[CTR_INSTRET_HI] = (cmd.csrNum == CSR_MINSTRETH);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusMie   <= 1'b0;
            statusMpie  <= 1'b0;
            mieReg      <= '0;
            mtvecReg    <= '0;
            mscratchReg <= '0;
            mepcReg     <= '0;
            mcauseReg   <= '0;
            mtvalReg    <= '0;
            mipTimer    <= 1'b0;
            mipExt      <= 1'b0;
        end else begin
            mipTimer <= timerIrq;   // Level lines, sampled every edge
            mipExt   <= extIrq;
            case (cmd.kind)
                CMD_OP: begin
                    case (cmd.csrNum)
                        CSR_MSTATUS: begin
                            statusMie  <= newVal[MIE_BIT];
                            statusMpie <= newVal[MPIE_BIT];
                        end
                        CSR_MIE:      mieReg      <= newVal;
                        CSR_MTVEC:    mtvecReg    <= {newVal[XLEN-1:2], 2'b00};
                        CSR_MSCRATCH: mscratchReg <= newVal;
                        CSR_MEPC:     mepcReg     <= newVal;
                        CSR_MCAUSE:   mcauseReg   <= newVal;
                        CSR_MTVAL:    mtvalReg    <= newVal;
                        default: ;  // mip read-only, counters go out on ctrWrite
                    endcase
                end
                CMD_TRAP, CMD_IRQ: begin
                    statusMpie <= statusMie;
                    statusMie  <= 1'b0;
                    mepcReg    <= cmd.epc;
                    mtvalReg   <= (cmd.kind == CMD_IRQ) ? cmd.epc : cmd.tval;
                    mcauseReg  <= {cmd.kind == CMD_IRQ, {(XLEN-CAUSE_W-1){1'b0}}, cmd.cause};
                end
                CMD_MRET: statusMie <= statusMpie;
                default: ;
            endcase
        end
    end

    assign mtvecBase = mtvecReg;
    assign mepc      = mepcReg;
    assign mieBits   = mieReg;
    assign mipBits   = mipVal;
    assign globalIe  = statusMie;

endmodule

//--- trapControl.sv
// CSR request controller
// Accepts one request at a time, swaps in a pending interrupt,
// issues a single command to the CSR file and holds the response
`timescale 1ns/1ps

module trapControl (
    input  logic             clk,
    input  logic             arstN,
    input  logic             reqValid,
    output logic             reqReady,
    input  csrPkg::csrReqT   req,
    output logic             respValid,
    input  logic             respReady,
    output csrPkg::csrRespT  resp,
    input  logic             irqValid,
    input  csrPkg::causeT    irqCause,
    input  csrPkg::wordT     rdata,
    input  csrPkg::addrT     mtvecBase,
    input  csrPkg::addrT     mepc,
    output csrPkg::csrCmdT   cmd
);
    import csrPkg::*;

    ctrlStateT state;
    cmdKindT   acceptKind;
    csrRespT   respReg;
    csrRespT   respNext;
    logic      accept;

    assign reqReady  = (state == S_IDLE);
    assign respValid = (state == S_RESP);
    assign accept    = reqValid && reqReady;

    // Interrupt takes the slot of the request
    always_comb begin
        if (irqValid) begin
            acceptKind = CMD_IRQ;
        end else begin
            case (req.kind)
                REQ_CSRRW, REQ_CSRRS, REQ_CSRRC: acceptKind = CMD_OP;
                REQ_TRAP: acceptKind = CMD_TRAP;
                REQ_MRET: acceptKind = CMD_MRET;
                default:  acceptKind = CMD_NONE;
            endcase
        end
    end

    always_comb begin
        cmd.kind   = accept ? acceptKind : CMD_NONE;   // Valid in accept cycle only
        cmd.op     = req.kind;
        cmd.csrNum = req.csrNum;
        cmd.wdata  = req.wdata;
        cmd.epc    = req.pc;
        cmd.tval   = req.tval;
        cmd.cause  = irqValid ? irqCause : req.cause;
    end

    always_comb begin
        respNext.rdata    = (acceptKind == CMD_OP) ? rdata : '0;   // Old CSR value
        respNext.redirect = acceptKind inside {CMD_TRAP, CMD_MRET, CMD_IRQ};
        respNext.irqTaken = (acceptKind == CMD_IRQ);
        case (acceptKind)
            CMD_MRET:          respNext.target = mepc;
            CMD_TRAP, CMD_IRQ: respNext.target = mtvecBase;
            default:           respNext.target = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (accept) state <= S_RESP;
                S_RESP: if (respReady) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Response payload, stable while held
    always_ff @(posedge clk) begin
        if (accept) begin
            respReg <= respNext;
        end
    end

    assign resp = respReg;

endmodule

//--- csrSubsystem.sv
// Machine-mode CSR subsystem top level
// Request controller, CSR file, counters and interrupt arbiter
`timescale 1ns/1ps

module csrSubsystem (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 reqValid,
    output logic                 reqReady,
    input  csrPkg::csrReqT       req,
    output logic                 respValid,
    input  logic                 respReady,
    output csrPkg::csrRespT      resp,
    input  logic                 timerIrq,
    input  logic                 extIrq,
    input  csrPkg::retireCountT  retireCount
);
    import csrPkg::*;

    csrCmdT   cmd;
    wordT     rdata;
    addrT     mtvecBase;
    addrT     mepc;
    wordT     mieBits;
    wordT     mipBits;
    logic     globalIe;
    ctrWriteT ctrWrite;
    ctrValueT counters;
    logic     irqValid;
    causeT    irqCause;

    trapControl trapControl_i (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp),
        .irqValid  (irqValid),
        .irqCause  (irqCause),
        .rdata     (rdata),
        .mtvecBase (mtvecBase),
        .mepc      (mepc),
        .cmd       (cmd)
    );

    csrFile csrFile_i (
        .clk       (clk),
        .arstN     (arstN),
        .cmd       (cmd),
        .timerIrq  (timerIrq),
        .extIrq    (extIrq),
        .counters  (counters),
        .ctrWrite  (ctrWrite),
        .rdata     (rdata),
        .mtvecBase (mtvecBase),
        .mepc      (mepc),
        .mieBits   (mieBits),
        .mipBits   (mipBits),
        .globalIe  (globalIe)
    );

    retireCounters retireCounters_i (
        .clk         (clk),
        .arstN       (arstN),
        .retireCount (retireCount),
        .ctrWrite    (ctrWrite),
        .counters    (counters)
    );

    interruptArbiter interruptArbiter_i (
        .mieBits  (mieBits),
        .mipBits  (mipBits),
        .globalIe (globalIe),
        .irqValid (irqValid),
        .irqCause (irqCause)
    );

endmodule

//--- csrTb.sv
// Testbench for the machine-mode CSR subsystem
// Random requests, interrupt lines and retire counts from an xorshift
// generator, checked against a cycle-level model of the CSRs and counters
`timescale 1ns/1ps

module csrTb;
    import csrPkg::*;

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 20 + 500;

    logic        clk;
    logic        arstN;
    logic        reqValid;
    logic        reqReady;
    csrReqT      req;
    logic        respValid;
    logic        respReady;
    csrRespT     resp;
    logic        timerIrq;
    logic        extIrq;
    retireCountT retireCount;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] rngState;

    // Model of the architectural state
    logic    mBusy;
    logic    mStatusMie;
    logic    mStatusMpie;
    wordT    mMie;
    addrT    mMtvec;
    wordT    mMscratch;
    addrT    mMepc;
    wordT    mMcause;
    wordT    mMtval;
    wordT    mMip;
    ctrT     mCycle;
    ctrT     mInstret;
    csrRespT expQ[$];   // Expected responses, oldest first
    int      accepted;
    int      respCount;

    csrSubsystem csrSubsystem_i (
        .clk         (clk),
        .arstN       (arstN),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .respValid   (respValid),
        .respReady   (respReady),
        .resp        (resp),
        .timerIrq    (timerIrq),
        .extIrq      (extIrq),
        .retireCount (retireCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Implemented CSRs plus one unmapped number
    function automatic csrNumT pickCsr(input logic [3:0] idx);
        case (idx)
            4'd0:    return CSR_MSTATUS;
            4'd1:    return CSR_MIE;
            4'd2:    return CSR_MTVEC;
            4'd3:    return CSR_MSCRATCH;
            4'd4:    return CSR_MEPC;
            4'd5:    return CSR_MCAUSE;
            4'd6:    return CSR_MTVAL;
            4'd7:    return CSR_MIP;
            4'd8:    return CSR_MCYCLE;
            4'd9:    return CSR_MINSTRET;
            4'd10:   return CSR_MCYCLEH;
            4'd11:   return CSR_MINSTRETH;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic csrReqT makeReq();
        csrReqT      r;
        logic [31:0] k;
        logic [31:0] sel;
        logic [31:0] tmp;
        k        = nextRand() % 32'd5;
        sel      = nextRand() % 32'd13;
        r.kind   = reqKindT'(k[2:0]);
        r.csrNum = pickCsr(sel[3:0]);
        r.wdata  = nextRand();
        r.pc     = nextRand();
        r.tval   = nextRand();
        tmp      = nextRand();
        r.cause  = tmp[4:0];
        if (tmp[7:5] == 3'd0) begin
            r.wdata = {28'hFFFFFFF, tmp[11:8]};   // Low half near wrap, forces a carry
        end else if (tmp[9:8] == 2'd0 && r.kind != REQ_CSRRW) begin
            r.wdata = '0;   // Plain read
        end
        return r;
    endfunction

    function automatic wordT modelRead(input csrNumT n);
        wordT v;
        v = '0;
        case (n)
            CSR_MSTATUS: begin
                v[MIE_BIT]  = mStatusMie;
                v[MPIE_BIT] = mStatusMpie;
            end
            CSR_MIE:       v = mMie;
            CSR_MTVEC:     v = mMtvec;
            CSR_MSCRATCH:  v = mMscratch;
            CSR_MEPC:      v = mMepc;
            CSR_MCAUSE:    v = mMcause;
            CSR_MTVAL:     v = mMtval;
            CSR_MIP:       v = mMip;
            CSR_MCYCLE:    v = mCycle[31:0];
            CSR_MCYCLEH:   v = mCycle[63:32];
            CSR_MINSTRET:  v = mInstret[31:0];
            CSR_MINSTRETH: v = mInstret[63:32];
            default:       v = '0;
        endcase
        return v;
    endfunction

    task automatic modelWrite(input csrNumT n, input wordT v,
                              output logic cycWr, output logic instWr);
        cycWr  = 1'b0;
        instWr = 1'b0;
        case (n)
            CSR_MSTATUS: begin
                mStatusMie  = v[MIE_BIT];
                mStatusMpie = v[MPIE_BIT];
            end
            CSR_MIE:      mMie      = v;
            CSR_MTVEC:    mMtvec    = {v[31:2], 2'b00};
            CSR_MSCRATCH: mMscratch = v;
            CSR_MEPC:     mMepc     = v;
            CSR_MCAUSE:   mMcause   = v;
            CSR_MTVAL:    mMtval    = v;
            CSR_MCYCLE: begin
                mCycle[31:0] = v;
                cycWr        = 1'b1;
            end
            CSR_MCYCLEH: begin
                mCycle[63:32] = v;
                cycWr         = 1'b1;
            end
            CSR_MINSTRET: begin
                mInstret[31:0] = v;
                instWr         = 1'b1;
            end
            CSR_MINSTRETH: begin
                mInstret[63:32] = v;
                instWr          = 1'b1;
            end
            default: ;   // mip and unmapped numbers keep their value
        endcase
    endtask

    task automatic enterTrap(input addrT epc, input wordT tval, input causeT cause,
                             input logic isIrq);
        mStatusMpie = mStatusMie;
        mStatusMie  = 1'b0;
        mMepc       = epc;
        mMtval      = tval;
        mMcause     = {isIrq, 26'd0, cause};
    endtask

    task automatic resetModel();
        mBusy       = 1'b0;
        mStatusMie  = 1'b0;
        mStatusMpie = 1'b0;
        mMie        = '0;
        mMtvec      = '0;
        mMscratch   = '0;
        mMepc       = '0;
        mMcause     = '0;
        mMtval      = '0;
        mMip        = '0;
        mCycle      = '0;
        mInstret    = '0;
        accepted    = 0;
        respCount   = 0;
        expQ.delete();
    endtask

    task automatic checkResp(input csrRespT exp, input csrRespT got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED resp: expected rdata %h redirect %h target %h irqTaken %h",
                     exp.rdata, exp.redirect, exp.target, exp.irqTaken);
            $display("    got rdata %h redirect %h target %h irqTaken %h",
                     got.rdata, got.redirect, got.target, got.irqTaken);
        end
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    // Cycle-level model, stepped on the same edge as the DUT
    always @(posedge clk) begin
        csrRespT exp;
        wordT    old;
        wordT    nv;
        wordT    pend;
        logic    acc;
        logic    takeIrq;
        logic    cycWr;
        logic    instWr;
        if (!arstN) begin
            resetModel();
        end else begin
            cycWr  = 1'b0;
            instWr = 1'b0;
            acc    = reqValid && !mBusy;
            checkWord("reqReady", wordT'(!mBusy), wordT'(reqReady));
            checkWord("respValid", wordT'(mBusy), wordT'(respValid));
            if (mBusy) begin
                exp = expQ[0];
                if (respReady) begin
                    checkResp(exp, resp);
                    void'(expQ.pop_front());
                    respCount++;
                    mBusy = 1'b0;
                end else begin
                    checkResp(exp, resp);   // Held stable
                end
            end
            if (acc) begin
                accepted++;
                pend    = mMie & mMip;
                takeIrq = mStatusMie && (pend[MTI_BIT] || pend[MEI_BIT]);
                exp     = '0;
                if (takeIrq) begin
                    exp.redirect = 1'b1;
                    exp.target   = mMtvec;
                    exp.irqTaken = 1'b1;
                    enterTrap(req.pc, req.pc, pend[MEI_BIT] ? CAUSE_MEI : CAUSE_MTI, 1'b1);
                end else begin
                    case (req.kind)
                        REQ_TRAP: begin
                            exp.redirect = 1'b1;
                            exp.target   = mMtvec;
                            enterTrap(req.pc, req.tval, req.cause, 1'b0);
                        end
                        REQ_MRET: begin
                            exp.redirect = 1'b1;
                            exp.target   = mMepc;
                            mStatusMie   = mStatusMpie;
                        end
                        default: begin
                            old = modelRead(req.csrNum);
                            if (req.kind == REQ_CSRRS) begin
                                nv = old | req.wdata;
                            end else if (req.kind == REQ_CSRRC) begin
                                nv = old & ~req.wdata;
                            end else begin
                                nv = req.wdata;
                            end
                            exp.rdata = old;
                            modelWrite(req.csrNum, nv, cycWr, instWr);
                        end
                    endcase
                end
                expQ.push_back(exp);
                mBusy = 1'b1;
            end
            if (!cycWr) mCycle = mCycle + 64'd1;
            if (!instWr) mInstret = mInstret + ctrT'(retireCount);
            mMip          = '0;   // Lines as seen on this edge
            mMip[MTI_BIT] = timerIrq;
            mMip[MEI_BIT] = extIrq;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still active after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int          sent;
        int          respSeen;
        int          hold;
        int          endErrors;
        logic        reqOut;
        logic [31:0] r;
        rngState    = 32'h78327722;
        sent        = 0;
        respSeen    = 0;
        hold        = 0;
        endErrors   = 0;
        reqOut      = 1'b0;
        arstN       = 1'b0;
        reqValid    = 1'b0;
        req         = '0;
        respReady   = 1'b0;
        timerIrq    = 1'b0;
        extIrq      = 1'b0;
        retireCount = '0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        while (respSeen < NUM_REQ) begin
            @(posedge clk);
            if (respValid && respReady) respSeen++;
            if (reqValid && reqReady) begin
                sent++;
                reqOut = 1'b0;
                reqValid <= 1'b0;
            end
            r = nextRand();
            respReady <= (r[1:0] != 2'b00);   // Stall about one cycle in four
            if (hold == 0) begin
                retireCount <= r[3:2];
                timerIrq    <= r[4];
                extIrq      <= (r[7:5] == 3'd0);
                hold = int'(r[11:8]);
            end else begin
                hold--;
            end
            if (!reqOut && sent < NUM_REQ && r[13:12] != 2'b00) begin
                req      <= makeReq();
                reqValid <= 1'b1;
                reqOut = 1'b1;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (accepted != sent) begin
            endErrors++;
            $display("Model accepted %0d requests but %0d were handed over", accepted, sent);
        end
        if (respCount != NUM_REQ) begin
            endErrors++;
            $display("Got %0d responses for %0d requests", respCount, NUM_REQ);
        end
        if (expQ.size() != 0) begin
            endErrors++;
            $display("%0d expected responses never arrived", expQ.size());
        end
        $display("Summary: %0d checks, %0d errors", checks, errors + endErrors);
        if (errors + endErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
csrPkg.sv
retireCounters.sv
interruptArbiter.sv
csrFile.sv
trapControl.sv
csrSubsystem.sv
csrTb.sv

//--- Makefile
TOP = csrTb

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
